// File: flist.f
verilog/irq_sleep_pkg.sv
verilog/irq_arbiter.sv
verilog/bus_outstanding_cnt.sv
verilog/wfi_sleep_ctrl.sv
verilog/irq_sleep_top.sv
sim/tb_irq_sleep.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and check the log for failure
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_irq_sleep
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -f flist.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0

// File: sim/tb_irq_sleep.sv
//----------------------------------------------------------
// Testbench for the interrupt and sleep controller. A small
// reference model built from the timing rules feeds the
// assertions. The instruction side bus stays idle.
//----------------------------------------------------------

`timescale 1ns/100ps

module tb_irq_sleep
  import irq_sleep_pkg::*;
();

  // Test lengths in cycles, upper bounds
  localparam int unsigned RST_CYC = 16;
  localparam int unsigned RAND_CYC = 300;
  localparam int unsigned CYC_LIMIT = 2 * (RST_CYC + RAND_CYC + 48 + 40 + 20 + 30);

  logic clk_i, rst_ni, mstatus_mie_i;
  irq_vec_t irq_i, mie_i, mip_o;
  logic iside_req_i, iside_gnt_i, iside_rvalid_i;
  logic dside_req_i, dside_gnt_i, dside_rvalid_i;
  logic wb_valid_i, wb_err_i, wb_kill_i, wu_wfe_i;
  instr_t wb_instr_i;
  logic irq_ack_o, core_sleep_o, wfi_retire_o;
  irq_id_t irq_id_o;

  int err_cnt = 0;
  int err_mark = 0;
  int test_cnt = 0;
  int fail_cnt = 0;
  int unsigned cyc = 0;

  irq_sleep_top #(.OUTSTANDING_CNT_W(4)) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  //----------------------------------------------------------
  // Reference model
  //----------------------------------------------------------
  irq_vec_t ref_mip;
  irq_id_t ref_id;
  logic ref_ack, ack_q, d_nz_q, wb_d1, wb_d2, ref_sleep;
  logic [3:0] d_cnt;
  logic wb_ok, is_wfe, in_wb, any_en, wake, busy;

  assign wb_ok = wb_valid_i && !wb_err_i && !wb_kill_i;
  assign is_wfe = wb_ok && (wb_instr_i == WFE_INSTR);
  assign in_wb = is_wfe || (wb_ok && (wb_instr_i == WFI_INSTR));
  assign any_en = |(ref_mip & mie_i);
  assign wake = any_en || (wu_wfe_i && is_wfe);
  assign busy = (d_cnt != '0) || d_nz_q;

  // Fixed order 31 down to 16, then 11, 3, 7
  function automatic irq_id_t prio_winner(input irq_vec_t en);
    for (int i = NUM_IRQ - 1; i >= 16; i--) begin
      if (en[i]) begin
        return irq_id_t'(i);
      end
    end
    if (en[11]) begin
      return irq_id_t'(11);
    end else if (en[3]) begin
      return irq_id_t'(3);
    end else if (en[7]) begin
      return irq_id_t'(7);
    end
    return '0;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ref_mip <= '0;
      ref_ack <= 1'b0;
      ref_id <= '0;
      ack_q <= 1'b0;
      d_cnt <= '0;
      d_nz_q <= 1'b0;
      wb_d1 <= 1'b0;
      wb_d2 <= 1'b0;
      ref_sleep <= 1'b0;
    end else begin
      ref_mip <= irq_i & VALID_IRQ_MASK;
      ref_ack <= any_en && mstatus_mie_i && !ref_ack;
      if (any_en) begin
        ref_id <= prio_winner(ref_mip & mie_i);
      end
      ack_q <= irq_ack_o;
      if (dside_req_i && dside_gnt_i && !dside_rvalid_i) begin
        d_cnt <= d_cnt + 4'd1;
      end else if (dside_rvalid_i && !(dside_req_i && dside_gnt_i)) begin
        d_cnt <= d_cnt - 4'd1;
      end
      d_nz_q <= (d_cnt != '0);
      wb_d1 <= in_wb;
      wb_d2 <= wb_d1;
      ref_sleep <= in_wb && (ref_sleep || wb_d2) && !busy && !wake;
    end
  end

  task automatic log_mismatch(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("MISMATCH %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    err_cnt++;
  endtask

  task automatic flag_failure(input string what);
    $display("ERROR: %s at %0t", what, $time);
    err_cnt++;
  endtask

  //----------------------------------------------------------
  // Assertions
  //----------------------------------------------------------
  a_mip: assert property (@(posedge clk_i) disable iff (!rst_ni) mip_o == ref_mip)
    else log_mismatch("mip_o", mip_o, ref_mip);
  a_rsvd: assert property (@(posedge clk_i) disable iff (!rst_ni)
                           (mip_o & ~VALID_IRQ_MASK) == '0)
    else flag_failure("reserved bit set in mip_o");
  a_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) irq_ack_o == ref_ack)
    else log_mismatch("irq_ack_o", 32'(irq_ack_o), 32'(ref_ack));
  a_gap: assert property (@(posedge clk_i) disable iff (!rst_ni) !(irq_ack_o && ack_q))
    else flag_failure("irq_ack_o high on two cycles in a row");
  a_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
                         irq_ack_o |-> irq_id_o == ref_id)
    else log_mismatch("irq_id_o", 32'(irq_id_o), 32'(ref_id));
  a_sleep: assert property (@(posedge clk_i) disable iff (!rst_ni) core_sleep_o == ref_sleep)
    else log_mismatch("core_sleep_o", 32'(core_sleep_o), 32'(ref_sleep));
  a_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
                             wfi_retire_o == (in_wb && wake))
    else log_mismatch("wfi_retire_o", 32'(wfi_retire_o), 32'(in_wb && wake));

  //----------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------
  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt != err_mark) begin
      fail_cnt++;
      $display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - err_mark);
    end else begin
      $display("test %0d %s: passed", test_cnt, name);
    end
    err_mark = err_cnt;
  endtask

  task automatic wb_drive(input logic valid, input instr_t instr, input logic err,
                          input logic kill);
    wb_valid_i = valid;
    wb_instr_i = instr;
    wb_err_i = err;
    wb_kill_i = kill;
  endtask

  task automatic expect_awake(input int n);
    repeat (n) begin
      @(negedge clk_i);
      assert (!core_sleep_o)
        else flag_failure("core_sleep_o high while the core must stay awake");
    end
  endtask

  // Sleep is due exactly three edges after the word appears
  task automatic enter_sleep(input instr_t instr);
    @(negedge clk_i);
    wb_drive(1'b1, instr, 1'b0, 1'b0);
    expect_awake(2);
    @(negedge clk_i);
    assert (core_sleep_o)
      else flag_failure("core_sleep_o not set three edges after entry");
  endtask

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("Timeout: run passed the limit of %0d cycles", CYC_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h162d5ae0));
    rst_ni = 1'b0;
    irq_i = '0;
    mie_i = '0;
    mstatus_mie_i = 1'b0;
    iside_req_i = 1'b0;
    iside_gnt_i = 1'b0;
    iside_rvalid_i = 1'b0;
    dside_req_i = 1'b0;
    dside_gnt_i = 1'b0;
    dside_rvalid_i = 1'b0;
    wu_wfe_i = 1'b0;
    wb_drive(1'b0, '0, 1'b0, 1'b0);
    repeat (RST_CYC) @(negedge clk_i);
    rst_ni = 1'b1;

    repeat (RAND_CYC) begin
      @(negedge clk_i);
      irq_i = $urandom();
      mie_i = $urandom() & $urandom();
      mstatus_mie_i = ($urandom() % 4) != 0;
    end
    end_test("random interrupt traffic");

    // Pending lines with global enable off, then enables off
    @(negedge clk_i);
    irq_i = VALID_IRQ_MASK;
    mie_i = '1;
    mstatus_mie_i = 1'b0;
    repeat (20) @(negedge clk_i);
    mie_i = '0;
    mstatus_mie_i = 1'b1;
    repeat (20) @(negedge clk_i);
    irq_i = '0;
    repeat (4) @(negedge clk_i);
    end_test("ack gating");

    enter_sleep(WFI_INSTR);
    wb_drive(1'b0, '0, 1'b0, 1'b0);
    expect_awake(3);
    wb_drive(1'b1, WFI_INSTR, 1'b0, 1'b1);
    expect_awake(10);
    wb_drive(1'b1, WFI_INSTR, 1'b1, 1'b0);
    expect_awake(10);
    end_test("sleep entry");

    // Data side grant held without a response
    wb_drive(1'b1, WFI_INSTR, 1'b0, 1'b0);
    dside_req_i = 1'b1;
    dside_gnt_i = 1'b1;
    @(negedge clk_i);
    dside_req_i = 1'b0;
    dside_gnt_i = 1'b0;
    expect_awake(8);
    dside_rvalid_i = 1'b1;
    @(negedge clk_i);
    dside_rvalid_i = 1'b0;
    expect_awake(1);
    @(negedge clk_i);
    assert (core_sleep_o)
      else flag_failure("core_sleep_o not set after the bus went idle");
    end_test("bus busy blocks sleep");

    // Interrupt wake, WFE wake, then WFE input ignored for WFI
    mie_i = 32'h0010_0000;
    mstatus_mie_i = 1'b0;
    @(negedge clk_i);
    irq_i = 32'h0010_0000;
    // WFI stays in writeback through the cycle the wake is seen
    repeat (2) @(negedge clk_i);
    irq_i = '0;
    wb_drive(1'b0, '0, 1'b0, 1'b0);
    expect_awake(1);
    enter_sleep(WFE_INSTR);
    wu_wfe_i = 1'b1;
    expect_awake(1);
    wu_wfe_i = 1'b0;
    wb_drive(1'b0, '0, 1'b0, 1'b0);
    expect_awake(1);
    enter_sleep(WFI_INSTR);
    wu_wfe_i = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      assert (core_sleep_o)
        else flag_failure("WFE wake input woke a WFI");
    end
    wu_wfe_i = 1'b0;
    wb_drive(1'b0, '0, 1'b0, 1'b0);
    repeat (2) @(negedge clk_i);
    end_test("wake and retire");

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_irq_sleep

// File: verilog/irq_sleep_top.sv
//----------------------------------------------------------
// Interrupt and sleep controller top level. Both bus ports
// use req/gnt/rvalid with no back-pressure on responses.
// OUTSTANDING_CNT_W sets the width of both counters.
//----------------------------------------------------------

`timescale 1ns/100ps

module irq_sleep_top
  import irq_sleep_pkg::*;
#(
  parameter int unsigned OUTSTANDING_CNT_W = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Interrupts
  input  irq_vec_t irq_i,
  input  irq_vec_t mie_i,
  input  logic     mstatus_mie_i,

  // Instruction side bus
  input  logic     iside_req_i,
  input  logic     iside_gnt_i,
  input  logic     iside_rvalid_i,

  // Data side bus
  input  logic     dside_req_i,
  input  logic     dside_gnt_i,
  input  logic     dside_rvalid_i,

  // Writeback stage
  input  logic     wb_valid_i,
  input  instr_t   wb_instr_i,
  input  logic     wb_err_i,
  input  logic     wb_kill_i,
  input  logic     wu_wfe_i,

  output irq_vec_t mip_o,
  output logic     irq_ack_o,
  output irq_id_t  irq_id_o,
  output logic     core_sleep_o,
  output logic     wfi_retire_o
);

  logic irq_wake;
  logic iside_busy;
  logic dside_busy;
  logic bus_busy;

  irq_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie_i),
    .mstatus_mie_i (mstatus_mie_i),
    .mip_o         (mip_o),
    .irq_wake_o    (irq_wake),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  //----------------------------------------------------------
  // Bus activity
  //----------------------------------------------------------

  bus_outstanding_cnt #(.CNT_W(OUTSTANDING_CNT_W)) u_iside_cnt (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (iside_req_i),
    .gnt_i    (iside_gnt_i),
    .rvalid_i (iside_rvalid_i),
    .busy_o   (iside_busy)
  );

  bus_outstanding_cnt #(.CNT_W(OUTSTANDING_CNT_W)) u_dside_cnt (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (dside_req_i),
    .gnt_i    (dside_gnt_i),
    .rvalid_i (dside_rvalid_i),
    .busy_o   (dside_busy)
  );

  // Either port blocks sleep
  assign bus_busy = iside_busy | dside_busy;

  wfi_sleep_ctrl u_sleep (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_valid_i   (wb_valid_i),
    .wb_instr_i   (wb_instr_i),
    .wb_err_i     (wb_err_i),
    .wb_kill_i    (wb_kill_i),
    .bus_busy_i   (bus_busy),
    .irq_wake_i   (irq_wake),
    .wu_wfe_i     (wu_wfe_i),
    .core_sleep_o (core_sleep_o),
    .wfi_retire_o (wfi_retire_o)
  );

endmodule : irq_sleep_top

// File: verilog/wfi_sleep_ctrl.sv
//----------------------------------------------------------
// WFI and WFE sleep model. The word must stay in writeback,
// unkilled and error free, for SLEEP_ENTRY_CYCLES cycles
// with both buses idle and no wake before the core sleeps.
// The WFE wake input counts only while a WFE is in writeback.
//----------------------------------------------------------

`timescale 1ns/100ps

module wfi_sleep_ctrl
  import irq_sleep_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,

  // Writeback stage
  input  logic   wb_valid_i,
  input  instr_t wb_instr_i,
  input  logic   wb_err_i,
  input  logic   wb_kill_i,

  // Sleep blockers and wake sources
  input  logic   bus_busy_i,
  input  logic   irq_wake_i,
  input  logic   wu_wfe_i,

  output logic   core_sleep_o,
  output logic   wfi_retire_o
);

  // Number of delay stages behind the current writeback match
  localparam int unsigned HIST_W = SLEEP_ENTRY_CYCLES - 1;

  logic              wb_ok;
  logic              is_wfe;
  logic              in_wb;
  logic              wake;
  logic [HIST_W-1:0] in_wb_hist_q;
  logic              sleep_d;
  logic              sleep_q;

  //----------------------------------------------------------
  // Writeback decode
  //----------------------------------------------------------

  assign wb_ok  = wb_valid_i & ~wb_err_i & ~wb_kill_i;
  assign is_wfe = wb_ok & (wb_instr_i == WFE_INSTR);
  assign in_wb  = is_wfe | (wb_ok & (wb_instr_i == WFI_INSTR));

  assign wake = irq_wake_i | (wu_wfe_i & is_wfe);

  // Stage 0 is one cycle old, the top stage is the oldest
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_wb_hist_q <= '0;
    end else begin
      in_wb_hist_q[0] <= in_wb;
      for (int i = 1; i < HIST_W; i++) begin
        in_wb_hist_q[i] <= in_wb_hist_q[i-1];
      end
    end
  end

  //----------------------------------------------------------
  // Sleep state
  //----------------------------------------------------------

  // Once asleep, staying in writeback holds the state
  assign sleep_d = in_wb & (sleep_q | in_wb_hist_q[HIST_W-1]) &
                   ~bus_busy_i & ~wake;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else begin
      sleep_q <= sleep_d;
    end
  end

  assign core_sleep_o = sleep_q;

  // Retires in the cycle the wake is seen
  assign wfi_retire_o = in_wb & wake;

endmodule : wfi_sleep_ctrl

// File: verilog/bus_outstanding_cnt.sv
//----------------------------------------------------------
// Outstanding transaction counter for one bus port.
// A transaction is issued on req and gnt together and
// answered on rvalid. The count must stay below 2**CNT_W.
// Busy also covers the cycle after the last response.
//----------------------------------------------------------

`timescale 1ns/100ps

module bus_outstanding_cnt #(
  parameter int unsigned CNT_W = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  input  logic gnt_i,
  input  logic rvalid_i,
  output logic busy_o
);

  logic [CNT_W-1:0] cnt_q;
  logic             accept;
  logic             cnt_nz;
  logic             cnt_nz_q;

  assign accept = req_i & gnt_i;
  assign cnt_nz = (cnt_q != '0);

  // Accept and response in the same cycle leave the count alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (accept && !rvalid_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (rvalid_i && !accept) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // One cycle of history
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_nz_q <= 1'b0;
    end else begin
      cnt_nz_q <= cnt_nz;
    end
  end

  assign busy_o = cnt_nz | cnt_nz_q;

endmodule : bus_outstanding_cnt

// File: verilog/irq_arbiter.sv
//----------------------------------------------------------
// Machine interrupt pending register and fixed priority
// arbiter. Priority is 31 down to 16, then 11, 3, 7.
// The ack is a one-cycle pulse and never repeats on
// back-to-back cycles. Reserved lines are masked on entry.
//----------------------------------------------------------

`timescale 1ns/100ps

module irq_arbiter
  import irq_sleep_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  // External interrupt lines and CSR state
  input  irq_vec_t irq_i,
  input  irq_vec_t mie_i,
  input  logic     mstatus_mie_i,

  // Pending vector as seen by the CSR file
  output irq_vec_t mip_o,

  // Wake level for the sleep controller
  output logic     irq_wake_o,

  // Acknowledge towards the interrupt source
  output logic     irq_ack_o,
  output irq_id_t  irq_id_o
);

  irq_vec_t mip_q;
  irq_vec_t pend_en;
  logic     win_valid;
  irq_id_t  win_id;
  logic     ack_q;
  irq_id_t  id_q;

  //----------------------------------------------------------
  // Pending register
  //----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign mip_o = mip_q;

  // Pending and locally enabled, shared by arbitration and wake
  assign pend_en   = mip_q & mie_i;
  assign win_valid = |pend_en;

  //----------------------------------------------------------
  // Fixed priority selection
  //----------------------------------------------------------

  // Checked from lowest to highest priority so the last hit wins
  always_comb begin
    win_id = '0;
    if (pend_en[7]) begin
      win_id = irq_id_t'(7);
    end
    if (pend_en[3]) begin
      win_id = irq_id_t'(3);
    end
    if (pend_en[11]) begin
      win_id = irq_id_t'(11);
    end
    // Upper platform lines, higher index wins
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend_en[i]) begin
        win_id = irq_id_t'(i);
      end
    end
  end

  //----------------------------------------------------------
  // Acknowledge pulse
  //----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      // Low for one cycle after each ack
      ack_q <= win_valid & mstatus_mie_i & ~ack_q;
    end
  end

  // Id tracks the current winner whenever there is one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (win_valid) begin
      id_q <= win_id;
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

  // Wake ignores the global enable
  assign irq_wake_o = win_valid;

endmodule : irq_arbiter

// File: verilog/irq_sleep_pkg.sv
//----------------------------------------------------------
// Shared constants and types for the interrupt and sleep
// controller. Interrupt lines are fixed at 32 and only lines
// 31..16, 11, 7 and 3 are implemented.
//----------------------------------------------------------

package irq_sleep_pkg;

  //----------------------------------------------------------
  // Interrupt lines
  //----------------------------------------------------------
  localparam int unsigned NUM_IRQ = 32;

  // Lines 31..16 plus 11, 7 and 3
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  localparam int unsigned IRQ_ID_W = 5;

  typedef logic [NUM_IRQ-1:0]  irq_vec_t;
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  //----------------------------------------------------------
  // Instruction words
  //----------------------------------------------------------
  typedef logic [31:0] instr_t;

  localparam instr_t WFI_INSTR = 32'h1050_0073;

  // Custom encoding in the SYSTEM opcode space
  localparam instr_t WFE_INSTR = 32'h8c00_0073;

  // Consecutive writeback cycles before the core may sleep
  localparam int unsigned SLEEP_ENTRY_CYCLES = 3;

endpackage : irq_sleep_pkg
